// File: hdl/buffer_chain_if.sv
// -------------------------------------------------------------------------
// Buffer list access for the scatter and gather engines
// -------------------------------------------------------------------------
`timescale 1ns/1ps

interface buffer_chain_if
    import pkt_buf_pkg::*;
();
    // Allocation and linking
    logic     alloc_req;
    logic     alloc_vld;
    buf_ptr_t alloc_ptr;
    logic     link;
    buf_ptr_t link_from;
    buf_ptr_t link_to;

    // Chain walk and release
    buf_ptr_t lookup_ptr;
    buf_ptr_t next_ptr;
    logic     free;
    buf_ptr_t free_ptr;

    modport alloc      (output alloc_req, link, link_from, link_to,
                        input  alloc_vld, alloc_ptr);
    modport list_alloc (input  alloc_req, link, link_from, link_to,
                        output alloc_vld, alloc_ptr);
    modport walk       (output lookup_ptr, free, free_ptr, input next_ptr);
    modport list_walk  (input  lookup_ptr, free, free_ptr, output next_ptr);

endinterface : buffer_chain_if

// File: hdl/buffer_list.sv
// -------------------------------------------------------------------------
// Buffer list manager
// Circular free list plus the next-pointer table of the buffer chains
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module buffer_list
    import pkt_buf_pkg::*;
#(
    parameter int NUM_BUFFERS = 16
) (
    input  logic               clk,
    input  logic               srst,
    buffer_chain_if.list_alloc scatter_if,
    buffer_chain_if.list_walk  gather_if
);
    localparam int IDX_WID = $clog2(NUM_BUFFERS);
    localparam int CNT_WID = $clog2(NUM_BUFFERS + 1);

    buf_ptr_t           free_mem [NUM_BUFFERS];
    buf_ptr_t           next_tbl [NUM_BUFFERS];
    logic [IDX_WID-1:0] rd_idx;
    logic [IDX_WID-1:0] wr_idx;
    logic [CNT_WID-1:0] free_cnt;
    logic               pop;
    logic               push;

    assign pop  = scatter_if.alloc_req && scatter_if.alloc_vld;
    assign push = gather_if.free;

    assign scatter_if.alloc_vld = (free_cnt != '0);
    assign scatter_if.alloc_ptr = free_mem[rd_idx];

    // -----------------------------------------------------------------------
    // Free list
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_idx   <= '0;
            wr_idx   <= '0;
            free_cnt <= CNT_WID'(NUM_BUFFERS);
        end else begin
            if (pop) rd_idx <= rd_idx + 1'b1;
            if (push) wr_idx <= wr_idx + 1'b1;
            if (pop && !push) free_cnt <= free_cnt - 1'b1;
            else if (push && !pop) free_cnt <= free_cnt + 1'b1;
        end
    end

    // Starts out holding every buffer number once
    always_ff @(posedge clk) begin
        if (srst) begin
            for (int i = 0; i < NUM_BUFFERS; i++) begin
                free_mem[i] <= buf_ptr_t'(i);
            end
        end else if (push) begin
            free_mem[wr_idx] <= gather_if.free_ptr;
        end
    end

    // -----------------------------------------------------------------------
    // Chain links
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (scatter_if.link) next_tbl[scatter_if.link_from] <= scatter_if.link_to;
    end

    assign gather_if.next_ptr = next_tbl[gather_if.lookup_ptr];

endmodule : buffer_list

// File: hdl/ctxt_fifo.sv
// -------------------------------------------------------------------------
// Show-ahead context FIFO
// Head entry is visible on rd_data whenever rd_vld is high
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module ctxt_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           srst,
    input  logic                           wr,
    input  logic [WIDTH-1:0]               wr_data,
    output logic                           full,
    input  logic                           rd,
    output logic                           rd_vld,
    output logic [WIDTH-1:0]               rd_data,
    output logic [$clog2(DEPTH+1)-1:0]     count
);
    localparam int PTR_WID = $clog2(DEPTH);

    logic [WIDTH-1:0]   mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at the power-of-two depth
            if (wr) wr_ptr <= wr_ptr + 1'b1;
            if (rd) rd_ptr <= rd_ptr + 1'b1;
            if (wr && !rd) count <= count + 1'b1;
            else if (rd && !wr) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) mem[wr_ptr] <= wr_data;
    end

    assign full    = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign rd_vld  = (count != '0);
    assign rd_data = mem[rd_ptr];

endmodule : ctxt_fifo

// File: hdl/mem_port_if.sv
// -------------------------------------------------------------------------
// Packet memory client port
// -------------------------------------------------------------------------
`timescale 1ns/1ps

interface mem_port_if
    import pkt_buf_pkg::*;
#(
    parameter int ADDR_WID = 6
) ();
    logic                req;
    logic                wr;
    logic [ADDR_WID-1:0] addr;
    logic [DATA_WID-1:0] wdata;
    logic                gnt;
    logic                rvld;
    logic [DATA_WID-1:0] rdata;

    modport client (output req, wr, addr, wdata, input gnt, rvld, rdata);
    modport memory (input req, wr, addr, wdata, output gnt, rvld, rdata);

endinterface : mem_port_if

// File: hdl/packet_buffer_top.sv
// -------------------------------------------------------------------------
// Packet buffer top level
// Scatter, gather, buffer list and packet memory behind plain stream ports
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module packet_buffer_top
    import pkt_buf_pkg::*;
#(
    parameter int NUM_BUFFERS    = 16,
    parameter int BUFFER_WORDS   = 4,
    parameter int DESC_DEPTH     = 16,
    parameter int PREFETCH_DEPTH = 4
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                in_vld,
    output logic                in_rdy,
    input  logic [DATA_WID-1:0] in_data,
    input  logic                in_eop,
    input  logic [MTY_WID-1:0]  in_mty,
    output logic                out_vld,
    input  logic                out_rdy,
    output logic [DATA_WID-1:0] out_data,
    output logic                out_eop,
    output logic [MTY_WID-1:0]  out_mty,
    output logic                pkt_done
);
    localparam int ADDR_WID = $clog2(NUM_BUFFERS * BUFFER_WORDS);

    logic      desc_push;
    pkt_desc_t desc;
    logic      desc_full;

    mem_port_if #(.ADDR_WID(ADDR_WID)) scatter_mem_if ();
    mem_port_if #(.ADDR_WID(ADDR_WID)) gather_mem_if ();
    buffer_chain_if                    chain_if ();

    packet_scatter #(.BUFFER_WORDS(BUFFER_WORDS)) scatter_i (
        .clk, .srst,
        .in_vld, .in_rdy, .in_data, .in_eop, .in_mty,
        .mem_if    (scatter_mem_if),
        .chain_if  (chain_if),
        .desc_push, .desc, .desc_full
    );

    packet_gather #(
        .BUFFER_WORDS  (BUFFER_WORDS),
        .DESC_DEPTH    (DESC_DEPTH),
        .PREFETCH_DEPTH(PREFETCH_DEPTH)
    ) gather_i (
        .clk, .srst,
        .desc_push, .desc, .desc_full,
        .mem_if    (gather_mem_if),
        .chain_if  (chain_if),
        .out_vld, .out_rdy, .out_data, .out_eop, .out_mty, .pkt_done
    );

    buffer_list #(.NUM_BUFFERS(NUM_BUFFERS)) list_i (
        .clk, .srst,
        .scatter_if(chain_if),
        .gather_if (chain_if)
    );

    packet_mem_arb #(
        .NUM_BUFFERS (NUM_BUFFERS),
        .BUFFER_WORDS(BUFFER_WORDS)
    ) arb_i (
        .clk, .srst,
        .wr_port(scatter_mem_if),
        .rd_port(gather_mem_if)
    );

endmodule : packet_buffer_top

// File: hdl/packet_gather.sv
// -------------------------------------------------------------------------
// Gather engine
// Walks buffer chains by descriptor and streams packets out with prefetch
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module packet_gather
    import pkt_buf_pkg::*;
#(
    parameter int BUFFER_WORDS   = 4,
    parameter int DESC_DEPTH     = 16,
    parameter int PREFETCH_DEPTH = 4
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                desc_push,
    input  pkt_desc_t           desc,
    output logic                desc_full,
    mem_port_if.client          mem_if,
    buffer_chain_if.walk        chain_if,
    output logic                out_vld,
    input  logic                out_rdy,
    output logic [DATA_WID-1:0] out_data,
    output logic                out_eop,
    output logic [MTY_WID-1:0]  out_mty,
    output logic                pkt_done
);
    localparam int WIDX_WID = $clog2(BUFFER_WORDS);
    localparam int ADDR_WID = BUF_PTR_WID + WIDX_WID;
    localparam int CNT_WID  = $clog2(PREFETCH_DEPTH + 1);

    // Per-read context, ptr and buf_last release the buffer at the output
    typedef struct packed {
        logic               eop;
        logic [MTY_WID-1:0] mty;
        logic               buf_last;
        buf_ptr_t           ptr;
    } rd_ctxt_t;

    typedef struct packed {
        logic [DATA_WID-1:0] data;
        rd_ctxt_t            ctxt;
    } pf_entry_t;

    gather_state_t           state;
    logic                    desc_vld;
    pkt_desc_t               head_desc;
    logic                    pkt_start;
    buf_ptr_t                cur_ptr;
    logic [PKT_SIZE_WID-1:0] rem;
    logic [WIDX_WID-1:0]     word_idx;
    buf_ptr_t                sel_ptr;
    logic [PKT_SIZE_WID-1:0] sel_rem;
    logic [WIDX_WID-1:0]     cur_idx;
    logic                    rd_last;
    logic                    buf_end;
    logic                    issue;
    logic [CNT_WID-1:0]      ctxt_count;
    logic [CNT_WID-1:0]      pf_count;
    logic [CNT_WID:0]        in_flight;
    logic                    accept;
    rd_ctxt_t                rd_ctxt_in;
    rd_ctxt_t                rd_ctxt_out;
    pf_entry_t               pf_in;
    pf_entry_t               pf_out;

    ctxt_fifo #(.WIDTH($bits(pkt_desc_t)), .DEPTH(DESC_DEPTH)) desc_fifo_i (
        .clk, .srst,
        .wr(desc_push), .wr_data(desc), .full(desc_full),
        .rd(issue && rd_last), .rd_vld(desc_vld), .rd_data(head_desc), .count()
    );

    // -----------------------------------------------------------------------
    // Read FSM
    // -----------------------------------------------------------------------
    assign sel_ptr   = pkt_start ? head_desc.head : cur_ptr;
    assign sel_rem   = pkt_start ? head_desc.size : rem;
    assign cur_idx   = (state == READ_SOB) ? '0 : word_idx;
    assign rd_last   = (sel_rem <= PKT_SIZE_WID'(DATA_BYTES));
    assign buf_end   = rd_last || (cur_idx == WIDX_WID'(BUFFER_WORDS - 1));
    assign in_flight = {1'b0, ctxt_count} + {1'b0, pf_count};

    assign mem_if.req   = (!pkt_start || desc_vld) && (in_flight < PREFETCH_DEPTH);
    assign mem_if.wr    = 1'b0;
    assign mem_if.addr  = ADDR_WID'(sel_ptr * BUFFER_WORDS + cur_idx);
    assign mem_if.wdata = '0;
    assign issue        = mem_if.req && mem_if.gnt;

    assign chain_if.lookup_ptr = sel_ptr;

    always_ff @(posedge clk) begin
        if (srst) begin
            state     <= READ_SOB;
            pkt_start <= 1'b1;
        end else if (issue) begin
            pkt_start <= rd_last;
            state     <= buf_end ? READ_SOB : READ_MOB;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            rem      <= sel_rem - PKT_SIZE_WID'(DATA_BYTES);
            word_idx <= cur_idx + 1'b1;
            cur_ptr  <= buf_end ? chain_if.next_ptr : sel_ptr;
        end
    end

    // -----------------------------------------------------------------------
    // Read context and prefetch
    // -----------------------------------------------------------------------
    assign rd_ctxt_in.eop      = rd_last;
    assign rd_ctxt_in.mty      = rd_last ? MTY_WID'(PKT_SIZE_WID'(DATA_BYTES) - sel_rem) : '0;
    assign rd_ctxt_in.buf_last = buf_end;
    assign rd_ctxt_in.ptr      = sel_ptr;

    ctxt_fifo #(.WIDTH($bits(rd_ctxt_t)), .DEPTH(PREFETCH_DEPTH)) rd_ctxt_fifo_i (
        .clk, .srst,
        .wr(issue), .wr_data(rd_ctxt_in), .full(),
        .rd(mem_if.rvld), .rd_vld(), .rd_data(rd_ctxt_out), .count(ctxt_count)
    );

    assign pf_in.data = mem_if.rdata;
    assign pf_in.ctxt = rd_ctxt_out;

    ctxt_fifo #(.WIDTH($bits(pf_entry_t)), .DEPTH(PREFETCH_DEPTH)) prefetch_fifo_i (
        .clk, .srst,
        .wr(mem_if.rvld), .wr_data(pf_in), .full(),
        .rd(accept), .rd_vld(out_vld), .rd_data(pf_out), .count(pf_count)
    );

    assign accept   = out_vld && out_rdy;
    assign out_data = pf_out.data;
    assign out_eop  = pf_out.ctxt.eop;
    assign out_mty  = pf_out.ctxt.mty;
    assign pkt_done = accept && pf_out.ctxt.eop;

    // Buffer goes back once its last word has left
    assign chain_if.free     = accept && pf_out.ctxt.buf_last;
    assign chain_if.free_ptr = pf_out.ctxt.ptr;

endmodule : packet_gather

// File: hdl/packet_mem_arb.sv
// -------------------------------------------------------------------------
// Packet memory with round-robin arbitration between two clients
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module packet_mem_arb
    import pkt_buf_pkg::*;
#(
    parameter int NUM_BUFFERS  = 16,
    parameter int BUFFER_WORDS = 4
) (
    input  logic       clk,
    input  logic       srst,
    mem_port_if.memory wr_port,
    mem_port_if.memory rd_port
);
    localparam int DEPTH    = NUM_BUFFERS * BUFFER_WORDS;
    localparam int ADDR_WID = $clog2(DEPTH);

    logic [DATA_WID-1:0] mem [DEPTH];
    logic                last_wr;
    logic                wr_gnt;
    logic                rd_gnt;
    logic                acc_wr;
    logic [ADDR_WID-1:0] acc_addr;
    logic [DATA_WID-1:0] acc_wdata;
    logic [DATA_WID-1:0] rdata_q;
    logic                wr_rvld;
    logic                rd_rvld;

    // Under contention the client that lost last time wins
    assign wr_gnt = wr_port.req && (!rd_port.req || !last_wr);
    assign rd_gnt = rd_port.req && !wr_gnt;

    assign acc_wr    = wr_gnt ? wr_port.wr    : (rd_gnt && rd_port.wr);
    assign acc_addr  = wr_gnt ? wr_port.addr  : rd_port.addr;
    assign acc_wdata = wr_gnt ? wr_port.wdata : rd_port.wdata;

    always_ff @(posedge clk) begin
        if (srst) begin
            last_wr <= 1'b0;
            wr_rvld <= 1'b0;
            rd_rvld <= 1'b0;
        end else begin
            if (wr_gnt || rd_gnt) last_wr <= wr_gnt;
            wr_rvld <= wr_gnt && !wr_port.wr;
            rd_rvld <= rd_gnt && !rd_port.wr;
        end
    end

    // Single-port array
    always_ff @(posedge clk) begin
        if (acc_wr) mem[acc_addr] <= acc_wdata;
        rdata_q <= mem[acc_addr];
    end

    assign wr_port.gnt   = wr_gnt;
    assign wr_port.rvld  = wr_rvld;
    assign wr_port.rdata = rdata_q;
    assign rd_port.gnt   = rd_gnt;
    assign rd_port.rvld  = rd_rvld;
    assign rd_port.rdata = rdata_q;

endmodule : packet_mem_arb

// File: hdl/packet_scatter.sv
// -------------------------------------------------------------------------
// Scatter engine
// Writes packet words into chained buffers and issues descriptors
// -------------------------------------------------------------------------
`timescale 1ns/1ps

module packet_scatter
    import pkt_buf_pkg::*;
#(
    parameter int BUFFER_WORDS = 4
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                in_vld,
    output logic                in_rdy,
    input  logic [DATA_WID-1:0] in_data,
    input  logic                in_eop,
    input  logic [MTY_WID-1:0]  in_mty,
    mem_port_if.client          mem_if,
    buffer_chain_if.alloc       chain_if,
    output logic                desc_push,
    output pkt_desc_t           desc,
    input  logic                desc_full
);
    localparam int WIDX_WID = $clog2(BUFFER_WORDS);
    localparam int ADDR_WID = BUF_PTR_WID + WIDX_WID;

    scatter_state_t          state;
    logic                    init_done;
    buf_ptr_t                cur_ptr;
    buf_ptr_t                head_ptr;
    buf_ptr_t                wr_ptr;
    logic [WIDX_WID-1:0]     word_idx;
    logic [PKT_SIZE_WID-1:0] word_cnt;
    logic                    need_buf;
    logic                    accept;

    // A fresh buffer at packet start and after each full buffer
    assign need_buf = (state == IDLE) || (word_idx == '0);
    assign wr_ptr   = need_buf ? chain_if.alloc_ptr : cur_ptr;

    assign mem_if.req   = init_done && in_vld
                       && (!need_buf || chain_if.alloc_vld)
                       && !(in_eop && desc_full);
    assign mem_if.wr    = 1'b1;
    assign mem_if.addr  = ADDR_WID'(wr_ptr * BUFFER_WORDS + word_idx);
    assign mem_if.wdata = in_data;

    assign accept = mem_if.req && mem_if.gnt;
    assign in_rdy = accept;

    assign chain_if.alloc_req = accept && need_buf;
    assign chain_if.link      = accept && need_buf && (state == FILL);
    assign chain_if.link_from = cur_ptr;
    assign chain_if.link_to   = chain_if.alloc_ptr;

    // Descriptor goes out with the eop word
    assign desc_push = accept && in_eop;
    assign desc.head = (state == IDLE) ? chain_if.alloc_ptr : head_ptr;
    assign desc.size = PKT_SIZE_WID'((word_cnt + 1) * DATA_BYTES) - PKT_SIZE_WID'(in_mty);

    // -----------------------------------------------------------------------
    // Packet FSM
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state     <= IDLE;
            init_done <= 1'b0;
            word_idx  <= '0;
            word_cnt  <= '0;
        end else begin
            init_done <= 1'b1;
            if (accept) begin
                if (in_eop) begin
                    state    <= IDLE;
                    word_idx <= '0;
                    word_cnt <= '0;
                end else begin
                    state    <= FILL;
                    word_idx <= (word_idx == WIDX_WID'(BUFFER_WORDS - 1)) ? '0
                                                                          : word_idx + 1'b1;
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && need_buf) begin
            cur_ptr <= chain_if.alloc_ptr;
            if (state == IDLE) head_ptr <= chain_if.alloc_ptr;
        end
    end

endmodule : packet_scatter

// File: hdl/pkt_buf_pkg.sv
// -------------------------------------------------------------------------
// Packet buffer package
// Word and pointer widths, descriptor type and FSM state encodings
// -------------------------------------------------------------------------
package pkt_buf_pkg;

    localparam int DATA_BYTES   = 4;
    localparam int DATA_WID     = DATA_BYTES * 8;
    localparam int MTY_WID      = $clog2(DATA_BYTES);
    localparam int BUF_PTR_WID  = 4;
    localparam int PKT_SIZE_WID = 10;

    typedef logic [BUF_PTR_WID-1:0] buf_ptr_t;

    // Head of the buffer chain plus packet length in bytes
    typedef struct packed {
        buf_ptr_t                head;
        logic [PKT_SIZE_WID-1:0] size;
    } pkt_desc_t;

    typedef enum logic {
        IDLE,
        FILL
    } scatter_state_t;

    typedef enum logic {
        READ_SOB,
        READ_MOB
    } gather_state_t;

endpackage : pkt_buf_pkg

// File: run_sim.sh
#!/bin/sh
# Build and run the packet buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/Vpacket_buffer_tb

verilator --binary --timing --assert -Wno-fatal \
    --top-module packet_buffer_tb -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"$SIM" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    exit 0
fi
echo "Simulation reported failures, see $LOG"
exit 1

// File: test/packet_buffer_checker.sv
// ---------------------------------------------------------------------------
// Packet buffer checker
// Reference word queue and stream assertions, bound to the top level
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module packet_buffer_checker
    import pkt_buf_pkg::*;
(
    input logic                clk,
    input logic                srst,
    input logic                in_vld,
    input logic                in_rdy,
    input logic [DATA_WID-1:0] in_data,
    input logic                in_eop,
    input logic [MTY_WID-1:0]  in_mty,
    input logic                out_vld,
    input logic                out_rdy,
    input logic [DATA_WID-1:0] out_data,
    input logic                out_eop,
    input logic [MTY_WID-1:0]  out_mty,
    input logic                pkt_done
);
    localparam int REF_DEPTH = 256;

    logic [DATA_WID-1:0] ref_data [REF_DEPTH];
    logic                ref_eop  [REF_DEPTH];
    logic [MTY_WID-1:0]  ref_mty  [REF_DEPTH];
    logic [7:0]          wr_idx;
    logic [7:0]          rd_idx;
    logic [8:0]          pending;
    logic                in_acc;
    logic                out_acc;
    logic [DATA_WID-1:0] exp_data;
    logic                exp_eop;
    logic [MTY_WID-1:0]  exp_mty;
    int                  fail_cnt = 0;

    assign in_acc   = in_vld && in_rdy;
    assign out_acc  = out_vld && out_rdy;
    assign exp_data = ref_data[rd_idx];
    assign exp_eop  = ref_eop[rd_idx];
    assign exp_mty  = ref_mty[rd_idx];

    // Every accepted input word, in arrival order
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_idx  <= '0;
            rd_idx  <= '0;
            pending <= '0;
        end else begin
            if (in_acc) begin
                ref_data[wr_idx] <= in_data;
                ref_eop[wr_idx]  <= in_eop;
                ref_mty[wr_idx]  <= in_mty;
                wr_idx           <= wr_idx + 1'b1;
            end
            if (out_acc) rd_idx <= rd_idx + 1'b1;
            if (in_acc && !out_acc) pending <= pending + 1'b1;
            else if (out_acc && !in_acc) pending <= pending - 1'b1;
        end
    end

    // ---------------------------------------------------------------------------
    // Stream properties
    // ---------------------------------------------------------------------------
    a_order : assert property (@(posedge clk) disable iff (srst)
        out_acc |-> (pending != '0 && out_data == exp_data
                     && out_eop == exp_eop && out_mty == exp_mty))
    else begin
        $error("mismatch at %0t: output word differs from the input order", $time);
        fail_cnt++;
    end

    a_hold : assert property (@(posedge clk) disable iff (srst)
        (out_vld && !out_rdy) |=> (out_vld && $stable(out_data)
                                   && $stable(out_eop) && $stable(out_mty)))
    else begin
        $error("mismatch at %0t: output word changed while stalled", $time);
        fail_cnt++;
    end

    // Packet end taken from the reference queue
    a_done : assert property (@(posedge clk) disable iff (srst)
        pkt_done == (out_acc && exp_eop))
    else begin
        $error("mismatch at %0t: pkt_done does not follow the eop word", $time);
        fail_cnt++;
    end

    // Quiet outputs just after reset
    a_reset : assert property (@(posedge clk)
        srst |=> (!in_rdy && !out_vld && !pkt_done))
    else begin
        $error("mismatch at %0t: output active right after reset", $time);
        fail_cnt++;
    end

endmodule : packet_buffer_checker

bind packet_buffer_top packet_buffer_checker checker_i (.*);

// File: test/packet_buffer_tb.sv
// ---------------------------------------------------------------------------
// Packet buffer testbench
// Packet stimulus, output back-pressure, timeout and result summary
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module packet_buffer_tb
    import pkt_buf_pkg::*;
();
    localparam int SEED         = 32'h0322_10e4;
    localparam int MULTI_PKTS   = 8;
    localparam int RAND_PKTS    = 30;
    localparam int FULL_PKTS    = 16;
    localparam int REUSE_PKTS   = 4;
    localparam int BLOCK_CYCLES = 40;

    logic                clk;
    logic                srst;
    logic                in_vld;
    logic                in_rdy;
    logic [DATA_WID-1:0] in_data;
    logic                in_eop;
    logic [MTY_WID-1:0]  in_mty;
    logic                out_vld;
    logic                out_rdy;
    logic [DATA_WID-1:0] out_data;
    logic                out_eop;
    logic [MTY_WID-1:0]  out_mty;
    logic                pkt_done;
    logic                rdy_random;
    logic                rdy_level;
    int                  multi_len [MULTI_PKTS];
    int                  rand_len [RAND_PKTS];
    int                  reuse_len [REUSE_PKTS];
    int                  sent_cnt = 0;
    int                  done_cnt = 0;
    int                  err_cnt = 0;
    int                  cycle_cnt = 0;
    int                  cycle_limit = 1000000;

    packet_buffer_top dut_i (.*);

    always #2 clk = ~clk;

    // Receiver side, either a fixed level or a coin toss per cycle
    always @(posedge clk) begin
        if (rdy_random) out_rdy <= 1'($urandom_range(1, 0));
        else out_rdy <= rdy_level;
        if (srst) done_cnt <= 0;
        else if (pkt_done) done_cnt <= done_cnt + 1;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d packets came out",
                     cycle_cnt, done_cnt, sent_cnt);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int words_of(input int len_bytes);
        return (len_bytes + DATA_BYTES - 1) / DATA_BYTES;
    endfunction

    function automatic int errors_now();
        return err_cnt + dut_i.checker_i.fail_cnt;
    endfunction

    task automatic drive_word(input logic eop, input logic [MTY_WID-1:0] mty);
        in_vld  <= 1'b1;
        in_data <= $urandom();
        in_eop  <= eop;
        in_mty  <= mty;
    endtask

    // Returns on the rising edge where the word is taken
    task automatic wait_accept();
        do @(negedge clk); while (!in_rdy);
        @(posedge clk);
    endtask

    task automatic send_packet(input int len_bytes);
        int n_words;
        n_words = words_of(len_bytes);
        for (int w = 0; w < n_words; w++) begin
            if (w == n_words - 1) drive_word(1'b1, MTY_WID'(n_words * DATA_BYTES - len_bytes));
            else drive_word(1'b0, '0);
            wait_accept();
        end
        sent_cnt++;
    endtask

    task automatic stop_input();
        in_vld <= 1'b0;
        in_eop <= 1'b0;
    endtask

    task automatic wait_drain(input string name);
        while (done_cnt != sent_cnt) @(posedge clk);
        $display("Phase %s: %0d packets out, %0d errors so far", name, done_cnt, errors_now());
    endtask

    initial begin
        int total_words;
        void'($urandom(SEED));
        clk        = 1'b0;
        srst       = 1'b1;
        in_vld     = 1'b0;
        in_data    = '0;
        in_eop     = 1'b0;
        in_mty     = '0;
        out_rdy    = 1'b0;
        rdy_random = 1'b0;
        rdy_level  = 1'b1;

        // Timeout budget from the total stream length
        total_words = DATA_BYTES + FULL_PKTS * 4 + 1;
        foreach (multi_len[i]) begin
            multi_len[i] = $urandom_range(40, 17);
            total_words += words_of(multi_len[i]);
        end
        foreach (rand_len[i]) begin
            rand_len[i] = $urandom_range(40, 1);
            total_words += words_of(rand_len[i]);
        end
        foreach (reuse_len[i]) begin
            reuse_len[i] = $urandom_range(40, 1);
            total_words += words_of(reuse_len[i]);
        end
        cycle_limit = total_words * 12 + BLOCK_CYCLES + 500;

        repeat (2) @(posedge clk);
        srst <= 1'b0;

        for (int b = 1; b <= DATA_BYTES; b++) send_packet(b);
        stop_input();
        wait_drain("single word");

        foreach (multi_len[i]) send_packet(multi_len[i]);
        stop_input();
        wait_drain("multi buffer");

        rdy_random <= 1'b1;
        foreach (rand_len[i]) send_packet(rand_len[i]);
        stop_input();
        wait_drain("random ready");

        // Fill every buffer with the receiver stalled
        rdy_random <= 1'b0;
        rdy_level  <= 1'b0;
        repeat (2) @(posedge clk);
        for (int i = 0; i < FULL_PKTS; i++) send_packet(16);
        drive_word(1'b1, '0);
        repeat (BLOCK_CYCLES) begin
            @(negedge clk);
            assert (!in_rdy) else begin
                $display("Input accepted at %0t while every buffer was in use", $time);
                err_cnt++;
            end
        end
        rdy_level <= 1'b1;
        wait_accept();
        sent_cnt++;
        stop_input();
        wait_drain("buffers full");

        rdy_random <= 1'b1;
        foreach (reuse_len[i]) send_packet(reuse_len[i]);
        stop_input();
        wait_drain("buffer reuse");

        repeat (4) @(posedge clk);
        assert (dut_i.checker_i.pending == 0) else begin
            $display("mismatch at %0t: %0d input words never came out", $time,
                     dut_i.checker_i.pending);
            err_cnt++;
        end

        $display("Summary: %0d packets sent, %0d packets out, %0d errors",
                 sent_cnt, done_cnt, errors_now());
        if (errors_now() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : packet_buffer_tb

// File: verilog.f
hdl/pkt_buf_pkg.sv
hdl/mem_port_if.sv
hdl/buffer_chain_if.sv
hdl/ctxt_fifo.sv
hdl/buffer_list.sv
hdl/packet_scatter.sv
hdl/packet_gather.sv
hdl/packet_mem_arb.sv
hdl/packet_buffer_top.sv
test/packet_buffer_checker.sv
test/packet_buffer_tb.sv
